// ==== hw/render_pkg.sv ====
// shared widths, bus structs and table rules of the triangle set-up stage, used by scoped name
package render_pkg;

  localparam int C_WIDTH       = 18;  // camera position coordinate
  localparam int P_WIDTH       = 16;  // vertex coordinate
  localparam int V_WIDTH       = 16;  // unit vector component
  localparam int FRAC_BITS     = 14;
  localparam int UNIT          = 1 << FRAC_BITS;
  localparam int ZWIDTH        = 16;
  localparam int VW_OVER_TWO   = 160;
  localparam int VH_OVER_TWO   = 120;
  localparam int VIEW_X_WIDTH  = 20;
  localparam int VIEW_Y_WIDTH  = 18;
  localparam int DOT_WIDTH     = 40;  // dot3 accumulator
  localparam int NUM_TRI       = 2048;
  localparam int TRI_ID_WIDTH  = $clog2(NUM_TRI);
  localparam int NUM_COLORS    = 256;
  localparam int PAL_IDX_WIDTH = $clog2(NUM_COLORS);
  localparam int COLOR_WIDTH   = 16;  // rgb565

  typedef logic signed [C_WIDTH-1:0] cam_coord_t;
  typedef logic signed [P_WIDTH-1:0] vert_coord_t;
  typedef logic signed [V_WIDTH-1:0] vec_comp_t;
  typedef logic signed [C_WIDTH:0]   diff_t;     // vertex minus camera, one bit of headroom
  typedef vec_comp_t [2:0]           vec3_t;     // [0]=x [1]=y [2]=z
  typedef diff_t [2:0]               diff3_t;
  typedef logic signed [VIEW_X_WIDTH-1:0] view_x_t;
  typedef logic signed [VIEW_Y_WIDTH-1:0] view_y_t;
  typedef logic [ZWIDTH-1:0]         depth_t;

  typedef struct packed {
    cam_coord_t [2:0] pos;
    vec3_t            u;
    vec3_t            v;
    vec3_t            n;
  } camera_t;

  typedef struct packed {
    logic [TRI_ID_WIDTH-1:0] id;
    vert_coord_t [2:0][2:0]  vert;  // [vertex][axis]
  } triangle_t;

  typedef struct packed {
    view_x_t [2:0] x;
    view_y_t [2:0] y;
    depth_t  [2:0] z;
  } proj_t;

  typedef struct packed {
    logic pulse;
    logic reject;
  } engine_done_t;

  // one of four axis normals picked by the two low id bits
  function automatic vec3_t tri_normal(input int idx);
    vec3_t nrm;
    nrm = '0;
    case (idx % 4)
      0:       nrm[2] = vec_comp_t'(-UNIT);
      1:       nrm[2] = vec_comp_t'(UNIT);
      2:       nrm[0] = vec_comp_t'(-UNIT);
      default: nrm[1] = vec_comp_t'(-UNIT);
    endcase
    return nrm;
  endfunction

  // base rgb565 from the palette index
  function automatic logic [COLOR_WIDTH-1:0] palette_color(input int idx);
    logic [PAL_IDX_WIDTH-1:0] pidx;
    logic [4:0]               red;
    pidx = PAL_IDX_WIDTH'(idx % NUM_COLORS);
    red  = pidx[7:3];
    return {red, pidx[5:0], ~red};  // blue mirrors red
  endfunction

endpackage

// ==== hw/dot3.sv ====
// two-stage signed three-term dot product with a payload alongside, used by both engines
`timescale 1ns/100ps
module dot3 #(
  parameter type payload_t = logic
) (
  input  logic                                    clk_in,
  input  logic                                    rst_in,
  input  logic                                    strobe,
  input  render_pkg::diff3_t                      a,
  input  render_pkg::vec3_t                       b,
  input  payload_t                                payload_in,
  output logic                                    result_strobe,
  output logic signed [render_pkg::DOT_WIDTH-1:0] result,
  output payload_t                                payload_out
);

  logic signed [render_pkg::DOT_WIDTH-1:0] prod [3];  // stage 1 products
  logic                                    strobe_q;
  payload_t                                payload_q;
  logic signed [render_pkg::DOT_WIDTH-1:0] sum;

  // strobe pipe
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      strobe_q      <= 1'b0;
      result_strobe <= 1'b0;
    end else begin
      strobe_q      <= strobe;
      result_strobe <= strobe_q;
    end
  end

  // stage 1
  always_ff @(posedge clk_in) begin
    for (int k = 0; k < 3; k++) begin
      prod[k] <= a[k] * b[k];  // both signed, extends to accumulator width
    end
    payload_q <= payload_in;
  end

  assign sum = prod[0] + prod[1] + prod[2];

  // stage 2, back to integer scale
  always_ff @(posedge clk_in) begin
    result      <= sum >>> render_pkg::FRAC_BITS;
    payload_out <= payload_q;
  end

  // fixed two-cycle latency, engines count on it
  a_strobe_latency: assert property (
    @(posedge clk_in) disable iff (rst_in)
    result_strobe == $past(strobe, 2)
  ) else $error("dot3 result_strobe not two cycles after strobe");

endmodule

// ==== hw/vertex_pre_proc.sv ====
// projects three vertices to viewport and depth, flags bad depths; done 4 cycles after start
`timescale 1ns/100ps
module vertex_pre_proc (
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  logic                     start,
  input  render_pkg::triangle_t    triangle,
  input  render_pkg::camera_t      camera,
  output render_pkg::engine_done_t done,
  output render_pkg::proj_t        proj
);

  localparam int Z_MAX = (1 << render_pkg::ZWIDTH) - 1;

  typedef logic [1:0] vidx_t;  // vertex index riding through dot3

  logic                                    start_q;
  render_pkg::diff3_t                      diff [3];      // per vertex
  render_pkg::vec3_t                       axis [3];      // u, v, n
  logic [2:0][2:0]                         dot_strobe;    // [vertex][axis]
  logic signed [render_pkg::DOT_WIDTH-1:0] dot_res [3][3];
  vidx_t                                   dot_vidx [3][3];
  logic signed [render_pkg::DOT_WIDTH-1:0] slot [3][3];   // results sorted back by vertex index
  logic                                    all_strobe;
  render_pkg::proj_t                       proj_c;
  logic                                    reject_c;

  assign axis[0] = camera.u;
  assign axis[1] = camera.v;
  assign axis[2] = camera.n;

  // cycle 1: vertex differences
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start;
    end
  end

  always_ff @(posedge clk_in) begin
    for (int i = 0; i < 3; i++) begin
      for (int k = 0; k < 3; k++) begin
        diff[i][k] <= triangle.vert[i][k] - camera.pos[k];
      end
    end
  end

  // cycles 2 and 3: nine dot products
  for (genvar i = 0; i < 3; i++) begin : g_vert
    for (genvar j = 0; j < 3; j++) begin : g_axis
      dot3 #(
        .payload_t(vidx_t)
      ) dot_i (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .strobe       (start_q),
        .a            (diff[i]),
        .b            (axis[j]),
        .payload_in   (vidx_t'(i)),
        .result_strobe(dot_strobe[i][j]),
        .result       (dot_res[i][j]),
        .payload_out  (dot_vidx[i][j])
      );
    end
  end

  assign all_strobe = &dot_strobe;

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        slot[i][j] = '0;
      end
    end
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        slot[dot_vidx[i][j]][j] = dot_res[i][j];
      end
    end
  end

  // viewport offset and depth range
  always_comb begin
    reject_c = 1'b0;
    for (int i = 0; i < 3; i++) begin
      proj_c.x[i] = render_pkg::view_x_t'(render_pkg::VW_OVER_TWO + slot[i][0]);
      proj_c.y[i] = render_pkg::view_y_t'(render_pkg::VH_OVER_TWO - slot[i][1]);
      proj_c.z[i] = render_pkg::depth_t'(slot[i][2]);
      if (slot[i][2] <= 0 || slot[i][2] > Z_MAX) begin
        reject_c = 1'b1;  // behind camera or too far
      end
    end
  end

  // cycle 4
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      done <= '0;
    end else begin
      done.pulse  <= all_strobe;
      done.reject <= all_strobe & reject_c;
    end
  end

  always_ff @(posedge clk_in) begin
    if (all_strobe) begin
      proj <= reject_c ? '0 : proj_c;
    end
  end

  a_done_latency: assert property (
    @(posedge clk_in) disable iff (rst_in)
    done.pulse == $past(start, 4)
  ) else $error("projection done not four cycles after start");

endmodule

// ==== hw/shader.sv ====
// normal and color tables, back-face drop and facing scale; done 4 cycles after start
`timescale 1ns/100ps
module shader (
  input  logic                                 clk_in,
  input  logic                                 rst_in,
  input  logic                                 start,
  input  logic [render_pkg::TRI_ID_WIDTH-1:0]  tri_id,
  input  render_pkg::vec3_t                    cam_n,
  output render_pkg::engine_done_t             done,
  output logic [render_pkg::COLOR_WIDTH-1:0]   color
);

  typedef logic [render_pkg::COLOR_WIDTH-1:0] rgb_t;

  render_pkg::vec3_t                       normal_rom [render_pkg::NUM_TRI];
  rgb_t                                    palette_rom [render_pkg::NUM_COLORS];
  logic                                    start_q;
  render_pkg::vec3_t                       normal_q;
  rgb_t                                    base_q;
  render_pkg::diff3_t                      normal_ext;
  logic                                    res_strobe;
  logic signed [render_pkg::DOT_WIDTH-1:0] facing;
  logic signed [render_pkg::DOT_WIDTH-1:0] shade_raw;
  rgb_t                                    base_d;     // base color, aligned with facing
  logic                                    back_face;
  logic [3:0]                              intensity;
  logic [4:0]                              scale;
  logic [10:0]                             red_s;
  logic [10:0]                             grn_s;
  logic [10:0]                             blu_s;
  rgb_t                                    shaded;

  // fixed tables built from the package rules
  for (genvar t = 0; t < render_pkg::NUM_TRI; t++) begin : g_normal
    assign normal_rom[t] = render_pkg::tri_normal(t);
  end

  for (genvar c = 0; c < render_pkg::NUM_COLORS; c++) begin : g_palette
    assign palette_rom[c] = render_pkg::palette_color(c);
  end

  // cycle 1: table read
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start;
    end
  end

  always_ff @(posedge clk_in) begin
    if (start) begin
      normal_q <= normal_rom[tri_id];
      base_q   <= palette_rom[tri_id[render_pkg::PAL_IDX_WIDTH-1:0]];
    end
  end

  always_comb begin
    for (int k = 0; k < 3; k++) begin
      normal_ext[k] = normal_q[k];  // sign extend
    end
  end

  // cycles 2 and 3: normal against camera n
  dot3 #(
    .payload_t(rgb_t)
  ) facing_i (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .strobe       (start_q),
    .a            (normal_ext),
    .b            (cam_n),
    .payload_in   (base_q),
    .result_strobe(res_strobe),
    .result       (facing),
    .payload_out  (base_d)
  );

  assign back_face = (facing >= 0);
  assign shade_raw = (-facing) >>> (render_pkg::FRAC_BITS - 4);
  assign intensity = (shade_raw > 15) ? 4'd15 : shade_raw[3:0];  // saturate
  assign scale     = {1'b0, intensity} + 5'd1;

  // per channel times (intensity + 1) / 16
  assign red_s  = base_d[15:11] * scale;
  assign grn_s  = base_d[10:5] * scale;
  assign blu_s  = base_d[4:0] * scale;
  assign shaded = {red_s[8:4], grn_s[9:4], blu_s[8:4]};

  // cycle 4
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      done <= '0;
    end else begin
      done.pulse  <= res_strobe;
      done.reject <= res_strobe & back_face;
    end
  end

  always_ff @(posedge clk_in) begin
    if (res_strobe) begin
      color <= back_face ? '0 : shaded;
    end
  end

endmodule

// ==== hw/pre_proc_shader.sv ====
// set-up stage top level running both engines and holding one result under valid/ready
`timescale 1ns/100ps
module pre_proc_shader (
  input  logic                               clk_in,
  input  logic                               rst_in,
  input  logic                               valid_in,
  output logic                               ready_out,
  input  render_pkg::triangle_t              triangle,
  input  render_pkg::camera_t                camera,
  output logic                               valid_out,
  input  logic                               ready_in,
  output render_pkg::proj_t                  proj,
  output logic [render_pkg::COLOR_WIDTH-1:0] color
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_PROC,
    S_HOLD
  } state_t;

  state_t                               state;
  logic                                 start;     // one pulse into both engines
  render_pkg::triangle_t                tri_q;
  render_pkg::camera_t                  cam_q;
  render_pkg::engine_done_t             vp_done;
  render_pkg::engine_done_t             sh_done;
  render_pkg::proj_t                    vp_proj;
  logic [render_pkg::COLOR_WIDTH-1:0]   sh_color;
  logic                                 vp_got;
  logic                                 sh_got;
  logic                                 vp_rej;
  logic                                 sh_rej;

  vertex_pre_proc vertex_i (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .start   (start),
    .triangle(tri_q),
    .camera  (cam_q),
    .done    (vp_done),
    .proj    (vp_proj)
  );

  shader shader_i (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .start (start),
    .tri_id(tri_q.id),
    .cam_n (cam_q.n),
    .done  (sh_done),
    .color (sh_color)
  );

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state     <= S_IDLE;
      start     <= 1'b0;
      vp_got    <= 1'b0;
      sh_got    <= 1'b0;
      valid_out <= 1'b0;
      ready_out <= 1'b1;
    end else begin
      start <= 1'b0;
      case (state)
        S_IDLE: if (valid_in && ready_out) begin
          state     <= S_PROC;
          start     <= 1'b1;
          ready_out <= 1'b0;
        end
        S_PROC: begin
          if (vp_done.pulse) vp_got <= 1'b1;  // engines may finish in either order
          if (sh_done.pulse) sh_got <= 1'b1;
          if (vp_got && sh_got) begin
            vp_got <= 1'b0;
            sh_got <= 1'b0;
            if (vp_rej || sh_rej) begin
              state     <= S_IDLE;  // dropped, take the next one
              ready_out <= 1'b1;
            end else begin
              state     <= S_HOLD;
              valid_out <= 1'b1;
            end
          end
        end
        default: if (ready_in) begin
          state     <= S_IDLE;
          valid_out <= 1'b0;
          ready_out <= 1'b1;
        end
      endcase
    end
  end

  // input capture and per-engine result latches
  always_ff @(posedge clk_in) begin
    if (state == S_IDLE && valid_in && ready_out) begin
      tri_q <= triangle;
      cam_q <= camera;
    end
    if (vp_done.pulse) begin
      proj   <= vp_proj;
      vp_rej <= vp_done.reject;
    end
    if (sh_done.pulse) begin
      color  <= sh_color;
      sh_rej <= sh_done.reject;
    end
  end

  a_hold_stable: assert property (
    @(posedge clk_in) disable iff (rst_in)
    valid_out && !ready_in |=> valid_out && $stable(proj) && $stable(color)
  ) else $error("output changed while stalled");

  a_no_idle_done: assert property (
    @(posedge clk_in) disable iff (rst_in)
    state == S_IDLE |-> !vp_done.pulse && !sh_done.pulse
  ) else $error("engine done while idle");

endmodule

// ==== verification/render_model.svh ====
// reference rules for projection, depth test and shading; included inside the testbench module
`ifndef RENDER_MODEL_SVH
`define RENDER_MODEL_SVH

// q14 dot product, rounded toward minus infinity
function automatic longint model_dot(input longint d0, input longint d1, input longint d2,
                                     input render_pkg::vec3_t w);
  longint acc;
  acc = d0 * longint'($signed(w[0])) + d1 * longint'($signed(w[1]))
      + d2 * longint'($signed(w[2]));
  return acc >>> render_pkg::FRAC_BITS;
endfunction

task automatic model_project(input render_pkg::triangle_t t, input render_pkg::camera_t c,
                             output render_pkg::proj_t p, output bit drop);
  longint d [3];
  longint dn;
  p = '0;
  drop = 1'b0;
  for (int i = 0; i < 3; i++) begin
    for (int k = 0; k < 3; k++) begin
      d[k] = longint'($signed(t.vert[i][k])) - longint'($signed(c.pos[k]));
    end
    dn = model_dot(d[0], d[1], d[2], c.n);
    p.x[i] = render_pkg::view_x_t'(render_pkg::VW_OVER_TWO + model_dot(d[0], d[1], d[2], c.u));
    p.y[i] = render_pkg::view_y_t'(render_pkg::VH_OVER_TWO - model_dot(d[0], d[1], d[2], c.v));
    p.z[i] = render_pkg::depth_t'(dn);
    if (dn < 1 || dn >= (longint'(1) << render_pkg::ZWIDTH)) drop = 1'b1;
  end
  if (drop) p = '0;
endtask

task automatic model_color(input logic [10:0] id, input render_pkg::vec3_t n,
                           output logic [15:0] rgb, output bit drop);
  longint unit;
  longint facing;
  longint level;
  int     pal;
  int     red;
  int     grn;
  int     blu;
  unit = longint'(1) << render_pkg::FRAC_BITS;
  // axis normal chosen by id mod 4
  case (id % 4)
    0:       facing = model_dot(0, 0, -unit, n);
    1:       facing = model_dot(0, 0, unit, n);
    2:       facing = model_dot(-unit, 0, 0, n);
    default: facing = model_dot(0, -unit, 0, n);
  endcase
  drop  = (facing >= 0);  // back face
  level = (-facing) >>> (render_pkg::FRAC_BITS - 4);
  if (level > 15) level = 15;
  pal = id % render_pkg::NUM_COLORS;
  red = pal / 8;
  grn = pal % 64;
  blu = 31 - red;
  rgb = {5'((red * (level + 1)) >> 4), 6'((grn * (level + 1)) >> 4),
         5'((blu * (level + 1)) >> 4)};
  if (drop) rgb = '0;
endtask

`endif

// ==== verification/pre_proc_shader_tb.sv ====
// table-driven testbench for pre_proc_shader; each entry's result or drop is checked against the model
`timescale 1ns/100ps
module pre_proc_shader_tb;

  localparam int NUM_DIRECTED = 8;
  localparam int NUM_ENTRIES  = 20;
  localparam int MAX_CYCLES   = NUM_ENTRIES * 40;
  localparam int U            = render_pkg::UNIT;

  typedef struct packed {
    render_pkg::triangle_t triangle;
    render_pkg::camera_t   camera;
    logic [3:0]            stall;  // ready_in low cycles once valid_out rises
  } stim_t;

  logic                               clk_in;
  logic                               rst_in;
  logic                               valid_in;
  logic                               ready_out;
  render_pkg::triangle_t              triangle;
  render_pkg::camera_t                camera;
  logic                               valid_out;
  logic                               ready_in;
  render_pkg::proj_t                  proj;
  logic [render_pkg::COLOR_WIDTH-1:0] color;

  stim_t                              stim [NUM_ENTRIES];
  string                              names [NUM_ENTRIES];
  render_pkg::proj_t                  exp_proj [NUM_ENTRIES];
  logic [render_pkg::COLOR_WIDTH-1:0] exp_color [NUM_ENTRIES];
  bit                                 exp_drop [NUM_ENTRIES];
  logic [31:0]                        rng;
  int                                 err_count;
  int                                 take_count;
  int                                 cycle_count;

  `include "render_model.svh"

  pre_proc_shader dut_i (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .valid_in (valid_in),
    .ready_out(ready_out),
    .triangle (triangle),
    .camera   (camera),
    .valid_out(valid_out),
    .ready_in (ready_in),
    .proj     (proj),
    .color    (color)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // next random value in lo..hi
  function automatic int pick(input int lo, input int hi);
    rng = xorshift(rng);
    return lo + int'(rng % 32'(hi - lo + 1));
  endfunction

  function automatic render_pkg::vec3_t vec3(input int x, input int y, input int z);
    return {render_pkg::vec_comp_t'(z), render_pkg::vec_comp_t'(y), render_pkg::vec_comp_t'(x)};
  endfunction

  function automatic render_pkg::camera_t make_camera(input int px, input int py, input int pz,
      input render_pkg::vec3_t u, input render_pkg::vec3_t v, input render_pkg::vec3_t n);
    render_pkg::camera_t c;
    c.pos[0] = render_pkg::cam_coord_t'(px);
    c.pos[1] = render_pkg::cam_coord_t'(py);
    c.pos[2] = render_pkg::cam_coord_t'(pz);
    c.u = u;
    c.v = v;
    c.n = n;
    return c;
  endfunction

  function automatic render_pkg::triangle_t make_triangle(input int id,
      input render_pkg::vec3_t a, input render_pkg::vec3_t b, input render_pkg::vec3_t c);
    render_pkg::triangle_t t;
    t.id      = id[render_pkg::TRI_ID_WIDTH-1:0];
    t.vert[0] = a;  // same width as a vertex
    t.vert[1] = b;
    t.vert[2] = c;
    return t;
  endfunction

  task automatic add_entry(input int e, input string nm, input render_pkg::triangle_t t,
                           input render_pkg::camera_t c, input int stall);
    names[e]         = nm;
    stim[e].triangle = t;
    stim[e].camera   = c;
    stim[e].stall    = 4'(stall);
  endtask

  task automatic build_table();
    render_pkg::camera_t ident;
    render_pkg::camera_t rot_y;
    render_pkg::camera_t rot_x;
    bit                  vdrop;
    bit                  cdrop;
    ident = make_camera(0, 0, 0, vec3(U, 0, 0), vec3(0, U, 0), vec3(0, 0, U));
    // 30 degrees about y
    rot_y = make_camera(0, 0, 0, vec3(14189, 0, -8192), vec3(0, U, 0), vec3(8192, 0, 14189));
    rot_x = make_camera(100, -50, -500, vec3(U, 0, 0), vec3(0, 8192, -14189),
                        vec3(0, 14189, 8192));  // 60 degrees about x
    add_entry(0, "project_identity", make_triangle(168, vec3(10, 20, 100),
              vec3(-30, 5, 200), vec3(50, -40, 300)), ident, 0);
    add_entry(1, "reject_behind", make_triangle(4, vec3(0, 0, 100),
              vec3(10, 10, -50), vec3(20, 0, 80)), ident, 0);
    add_entry(2, "after_reject", make_triangle(496, vec3(-100, 60, 50),
              vec3(0, 0, 1), vec3(90, -70, 4000)), ident, 1);
    add_entry(3, "backface", make_triangle(213, vec3(5, 5, 50),
              vec3(15, 5, 60), vec3(5, 15, 70)), ident, 0);
    add_entry(4, "shade_rot_y", make_triangle(58, vec3(100, 50, 800),
              vec3(-200, 0, 900), vec3(0, -100, 1000)), rot_y, 0);
    add_entry(5, "shade_rot_x", make_triangle(711, vec3(120, 30, 400),
              vec3(80, 100, 600), vec3(150, -20, 500)), rot_x, 2);
    add_entry(6, "backpressure", make_triangle(1026, vec3(0, 0, 500),
              vec3(30, 30, 600), vec3(-30, 10, 700)), rot_y, 6);
    add_entry(7, "reject_far", make_triangle(0, vec3(0, 0, 32767), vec3(1, 1, 32767),
              vec3(2, 0, 32767)), make_camera(0, 0, -131072, ident.u, ident.v, ident.n), 0);
    for (int e = NUM_DIRECTED; e < NUM_ENTRIES; e++) begin
      add_entry(e, "random",
                make_triangle(pick(0, 2047),
                              vec3(pick(-2048, 2048), pick(-2048, 2048), pick(-512, 4095)),
                              vec3(pick(-2048, 2048), pick(-2048, 2048), pick(-512, 4095)),
                              vec3(pick(-2048, 2048), pick(-2048, 2048), pick(-512, 4095))),
                make_camera(pick(-1024, 1024), pick(-1024, 1024), pick(-1024, 0),
                            vec3(pick(-U, U), pick(-U, U), pick(-U, U)),
                            vec3(pick(-U, U), pick(-U, U), pick(-U, U)),
                            vec3(pick(-4096, 4096), pick(-4096, 4096), pick(U / 2, U - 1))),
                pick(0, 3));
    end
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      model_project(stim[e].triangle, stim[e].camera, exp_proj[e], vdrop);
      model_color(stim[e].triangle.id, stim[e].camera.n, exp_color[e], cdrop);
      exp_drop[e] = vdrop | cdrop;
    end
  endtask

  task automatic wrong_value(input string msg);
    err_count++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic handshake_fault(input string msg);
    err_count++;
    $display("handshake problem at %0t: %s", $time, msg);
  endtask

  task automatic run_entry(input int e);
    int                                 errs;
    int                                 taken;
    render_pkg::proj_t                  held_proj;
    logic [render_pkg::COLOR_WIDTH-1:0] held_color;
    errs  = err_count;
    taken = take_count;
    @(posedge clk_in);
    valid_in <= 1'b1;
    triangle <= stim[e].triangle;
    camera   <= stim[e].camera;
    ready_in <= (stim[e].stall == 0);
    @(negedge clk_in);
    while (!ready_out) @(negedge clk_in);
    @(posedge clk_in);  // accepting edge
    valid_in <= 1'b0;
    @(negedge clk_in);
    if (ready_out) handshake_fault("ready_out still high after the triangle was accepted");
    while (!valid_out && !ready_out) @(negedge clk_in);
    if (valid_out) begin
      if (exp_drop[e]) handshake_fault("a result came out for a triangle that should be dropped");
      if (proj !== exp_proj[e]) wrong_value($sformatf("proj %h, expected %h", proj, exp_proj[e]));
      if (color !== exp_color[e]) begin
        wrong_value($sformatf("color %h, expected %h", color, exp_color[e]));
      end
      held_proj  = proj;
      held_color = color;
      for (int s = 0; s < stim[e].stall; s++) begin
        @(negedge clk_in);
        if (!valid_out || ready_out) handshake_fault("valid_out fell or ready_out rose in a stall");
        if (proj !== held_proj || color !== held_color) wrong_value("output data moved in a stall");
      end
      if (stim[e].stall != 0) begin
        @(posedge clk_in);
        ready_in <= 1'b1;
        @(negedge clk_in);
      end
      @(negedge clk_in);
      if (valid_out || !ready_out) handshake_fault("result was not released after ready_in");
    end else if (!exp_drop[e]) begin
      handshake_fault("the triangle was dropped but a result was expected");
    end
    if (take_count - taken != (exp_drop[e] ? 0 : 1)) begin
      handshake_fault($sformatf("%0d results taken for one triangle", take_count - taken));
    end
    $display("test %0d %s: %s", e, names[e], (err_count == errs) ? "ok" : "failed");
  endtask

  // one count per completed output transfer
  always @(negedge clk_in) begin
    if (!rst_in && valid_out && ready_in) take_count <= take_count + 1;
  end

  initial begin
    clk_in = 1'b0;
    forever #4 clk_in = ~clk_in;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk_in);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rst_in     = 1'b1;
    valid_in   = 1'b0;
    ready_in   = 1'b0;
    triangle   = '0;
    camera     = '0;
    rng        = 32'h836b;
    err_count  = 0;
    take_count = 0;
    build_table();
    repeat (4) @(posedge clk_in);
    rst_in <= 1'b0;
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      run_entry(e);
    end
    $display("%0d tests, %0d errors, %0d results taken", NUM_ENTRIES, err_count, take_count);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== pre_proc_shader.f ====
+incdir+verification
hw/render_pkg.sv
hw/dot3.sv
hw/vertex_pre_proc.sv
hw/shader.sv
hw/pre_proc_shader.sv
verification/pre_proc_shader_tb.sv
